// ==== hdl/pcs_rx_params.svh ====
// width, fifo depth and 10g/40g select macros for the pcs rx path
`ifndef PCS_RX_PARAMS_SVH
`define PCS_RX_PARAMS_SVH

`default_nettype none

// block layout, 2-bit sync header in front of a 64-bit payload
`define PCS_HEAD_W 2
`define PCS_DATA_W 64

// one keep bit per payload byte
`define PCS_KEEP_W (`PCS_DATA_W / 8)

// full block as stored in the fifo
`define PCS_BLK_W (`PCS_HEAD_W + `PCS_DATA_W)

// block type field in byte 0 of a control block
`define PCS_TYPE_W 8

// 0 selects 10G, 1 selects 40G
`define PCS_IS_40G 0

// start lanes: 10G may start on lane 0 or 4, 40G only on lane 0
`define PCS_LANE0_CNT_N ((`PCS_IS_40G) ? 1 : 2)

// blocks held under back-pressure, power of two
`define PCS_FIFO_DEPTH 8

`default_nettype wire

`endif

// ==== hdl/pcs_rx_pkg.sv ====
// sync header enum, block type opcode enum and decode flag struct
`include "pcs_rx_params.svh"
`default_nettype none

package pcs_rx_pkg;

	// sync header, the only two legal encodings
	typedef enum logic [`PCS_HEAD_W-1:0] {
		SYNC_DATA = 2'b01, // eight data bytes
		SYNC_CTRL = 2'b10  // block type in byte 0
	} sync_head_e;

	// control block types known to the lite decoder
	typedef enum logic [`PCS_TYPE_W-1:0] {
		BT_CTRL    = 8'h1e, // all lanes control, idle
		BT_START_0 = 8'h78, // start in lane 0, data after
		BT_START_4 = 8'h33, // control in lanes 0-3, start in lane 4
		BT_OS_0    = 8'h4b, // ordered set in lane 0
		BT_TERM_0  = 8'h87, // terminate, no data bytes
		BT_TERM_1  = 8'h99,
		BT_TERM_2  = 8'haa,
		BT_TERM_3  = 8'hb4,
		BT_TERM_4  = 8'hcc,
		BT_TERM_5  = 8'hd2,
		BT_TERM_6  = 8'he1,
		BT_TERM_7  = 8'hff  // terminate after seven data bytes
	} block_type_e;

	// lite decode flags, not xgmii characters
	typedef struct packed {
		logic                          ctrl_v;  // control or malformed block
		logic                          idle_v;
		logic [`PCS_LANE0_CNT_N-1:0]   start_v; // bit 0 lane 0, bit 1 lane 4
		logic                          term_v;
		logic                          err_v;   // reception error
		logic                          ord_v;   // ordered set O0
	} dec_flags_t;

endpackage

`default_nettype wire

// ==== hdl/pcs_rx_blk_if.sv ====
// 66-bit block bus with valid strobe, sender and receiver modports
`include "pcs_rx_params.svh"
`default_nettype none

interface pcs_rx_blk_if;

	logic                   blk_v; // block counts only when high
	logic [`PCS_HEAD_W-1:0] head;  // sync header, never scrambled
	logic [`PCS_DATA_W-1:0] data;  // payload, byte 0 in the low bits

	// upstream side drives the block
	modport sender (
		output blk_v,
		output head,
		output data
	);

	// downstream side samples it, no ready back
	modport receiver (
		input blk_v,
		input head,
		input data
	);

endinterface

`default_nettype wire

// ==== hdl/descrambler_rx.sv ====
// registered self-synchronizing descrambler, polynomial 1 + x^39 + x^58
`include "pcs_rx_params.svh"
`default_nettype none

module descrambler_rx (
	input wire logic       clk,
	input wire logic       rst_i,
	pcs_rx_blk_if.receiver blk_i, // aligned scrambled blocks
	pcs_rx_blk_if.sender   blk_o  // descrambled, one cycle later
);

localparam int DATA_W = `PCS_DATA_W;
localparam int HIST_W = 58;              // long tap, state length
localparam int TAP_N  = 39;              // short tap
localparam int XT_W   = HIST_W + DATA_W; // history plus current block

// last 58 received scrambled bits
// bit 0 is the oldest, bit HIST_W-1 the most recent
logic [HIST_W-1:0] hist_q;

// serial stream view, oldest bit at 0, payload bit 0 at HIST_W
logic [XT_W-1:0]   stream;
logic [DATA_W-1:0] descr; // descrambled payload

assign stream = {blk_i.data, hist_q};

// out[n] = in[n] ^ in[n-39] ^ in[n-58], lsb first
always_comb begin
	for (int i = 0; i < DATA_W; i++) begin
		descr[i] = stream[HIST_W + i]          // received bit
			^ stream[HIST_W - TAP_N + i]       // 39 bits earlier
			^ stream[i];                       // 58 bits earlier
	end
end

// scrambler state follows the received bits, header ignored
always_ff @(posedge clk) begin
	if (rst_i) begin
		hist_q <= '0;
	end else if (blk_i.blk_v) begin
		hist_q <= stream[XT_W-1:DATA_W]; // keep the newest 58 bits
	end
end

// output stage
always_ff @(posedge clk) begin
	if (rst_i) begin
		blk_o.blk_v <= 1'b0;
	end else begin
		blk_o.blk_v <= blk_i.blk_v;
	end
end

always_ff @(posedge clk) begin
	if (blk_i.blk_v) begin
		blk_o.head <= blk_i.head; // header delayed as is
		blk_o.data <= descr;
	end
end

// a valid output block carries no x in header or payload
a_no_x_out: assert property (
	@(posedge clk) disable iff (rst_i)
	blk_o.blk_v |-> !$isunknown({blk_o.head, blk_o.data})
);

endmodule

`default_nettype wire

// ==== hdl/block_fifo.sv ====
// synchronous block fifo with hold-gated read and overflow pulse
`include "pcs_rx_params.svh"
`default_nettype none

module block_fifo (
	input wire logic       clk,
	input wire logic       rst_i,
	input wire logic       hold_i, // downstream holds reception off
	output logic           ovf_o,  // block dropped, one cycle pulse
	pcs_rx_blk_if.receiver wr_i,
	pcs_rx_blk_if.sender   rd_o
);

localparam int DEPTH = `PCS_FIFO_DEPTH;
localparam int AW    = $clog2(DEPTH);
localparam int BLK_W = `PCS_BLK_W;

logic [BLK_W-1:0] mem [DEPTH]; // {head, data} per entry

logic [AW-1:0] wr_ptr_q; // wraps, depth is a power of two
logic [AW-1:0] rd_ptr_q;
logic [AW:0]   cnt_q;    // occupancy, 0 to DEPTH
logic          full;
logic          empty;
logic          wr_en;
logic          rd_en;    // read launch
logic          rd_v_q;
logic [BLK_W-1:0] rd_blk_q;

assign full  = cnt_q == (AW+1)'(DEPTH);
assign empty = cnt_q == '0;
assign wr_en = wr_i.blk_v & ~full; // full fifo drops, even if a read launches
assign rd_en = ~empty & ~hold_i;

// storage, no reset
always_ff @(posedge clk) begin
	if (wr_en) begin
		mem[wr_ptr_q] <= {wr_i.head, wr_i.data};
	end
end

always_ff @(posedge clk) begin
	if (rst_i) begin
		wr_ptr_q <= '0;
		rd_ptr_q <= '0;
		cnt_q    <= '0;
		rd_v_q   <= 1'b0;
		ovf_o    <= 1'b0;
	end else begin
		if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
		if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
		case ({wr_en, rd_en})
			2'b10:   cnt_q <= cnt_q + 1'b1;
			2'b01:   cnt_q <= cnt_q - 1'b1;
			default: cnt_q <= cnt_q; // none or both
		endcase
		rd_v_q <= rd_en;                // block shows one cycle after launch
		ovf_o  <= wr_i.blk_v & full;    // dropped write
	end
end

// read data register
always_ff @(posedge clk) begin
	if (rd_en) begin
		rd_blk_q <= mem[rd_ptr_q];
	end
end

assign rd_o.blk_v = rd_v_q;
assign rd_o.head  = rd_blk_q[BLK_W-1 -: `PCS_HEAD_W];
assign rd_o.data  = rd_blk_q[`PCS_DATA_W-1:0];

// occupancy stays in range
a_cnt_max: assert property (
	@(posedge clk) disable iff (rst_i)
	cnt_q <= (AW+1)'(DEPTH)
);

// every block out was launched from a non-empty fifo
a_no_empty_rd: assert property (
	@(posedge clk) disable iff (rst_i)
	rd_o.blk_v |-> $past(cnt_q) != '0
);

endmodule

`default_nettype wire

// ==== hdl/dec_lite_rx.sv ====
// registered lite block decoder, decode flags, data and term keep mask
`include "pcs_rx_params.svh"
`default_nettype none

module dec_lite_rx
	import pcs_rx_pkg::*;
(
	input wire logic             clk,
	input wire logic             rst_i,
	pcs_rx_blk_if.receiver       blk_i,
	output logic                 blk_v_o,
	output logic                 ctrl_v_o,
	output logic                 idle_v_o,
	output logic [`PCS_LANE0_CNT_N-1:0] start_v_o,
	output logic                 term_v_o,
	output logic                 err_v_o,
	output logic                 ord_v_o,
	output logic [`PCS_DATA_W-1:0] data_o,
	output logic [`PCS_KEEP_W-1:0] keep_o
);

localparam int KEEP_W = `PCS_KEEP_W;
localparam int LANE_N = `PCS_LANE0_CNT_N;

logic [`PCS_TYPE_W-1:0] block_type; // byte 0 of a control block
logic              head_data;
logic              head_ctrl;
logic              idle_lite;
logic              ord_lite;
logic [KEEP_W-1:0] term_lite;  // one-hot on TERM_n
logic [LANE_N-1:0] start_lite;
logic              type_none;  // no known type matched
logic              ctl_ok;     // well formed control block
logic              block_nv;   // malformed block
logic [KEEP_W-1:0] term_ok;
dec_flags_t        flags_d;
dec_flags_t        flags_q;
logic              blk_v_q;
logic [`PCS_DATA_W-1:0] data_q;
logic [KEEP_W-1:0] keep_q;

assign block_type = blk_i.data[`PCS_TYPE_W-1:0];
assign head_data  = blk_i.head == SYNC_DATA;
assign head_ctrl  = blk_i.head == SYNC_CTRL;

// type match
assign idle_lite    = block_type == BT_CTRL;
assign ord_lite     = block_type == BT_OS_0; // O0 only
assign term_lite[0] = block_type == BT_TERM_0;
assign term_lite[1] = block_type == BT_TERM_1;
assign term_lite[2] = block_type == BT_TERM_2;
assign term_lite[3] = block_type == BT_TERM_3;
assign term_lite[4] = block_type == BT_TERM_4;
assign term_lite[5] = block_type == BT_TERM_5;
assign term_lite[6] = block_type == BT_TERM_6;
assign term_lite[7] = block_type == BT_TERM_7;
assign start_lite[0] = block_type == BT_START_0;

// start on lane 4 exists in 10G only, in 40G 0x33 is malformed
generate
	if (!`PCS_IS_40G) begin : gen_start_4
		assign start_lite[1] = block_type == BT_START_4;
	end
endgenerate

assign type_none = ~(idle_lite | ord_lite | (|term_lite) | (|start_lite));
assign ctl_ok    = head_ctrl & ~type_none;
assign block_nv  = ~(head_data | head_ctrl) | (head_ctrl & type_none);

// data blocks never carry a term, so keep reads all ones there
assign term_ok = term_lite & {KEEP_W{ctl_ok}};

always_comb begin
	flags_d = '0;
	if (blk_i.blk_v) begin
		flags_d.ctrl_v  = head_ctrl | block_nv;
		flags_d.idle_v  = idle_lite & ctl_ok;
		flags_d.ord_v   = ord_lite & ctl_ok;
		flags_d.term_v  = |term_ok;
		flags_d.start_v = start_lite & {LANE_N{ctl_ok}};
		flags_d.err_v   = block_nv; // masks every type flag above
	end
end

always_ff @(posedge clk) begin
	if (rst_i) begin
		flags_q <= '0;
		blk_v_q <= 1'b0;
	end else begin
		flags_q <= flags_d;
		blk_v_q <= blk_i.blk_v;
	end
end

always_ff @(posedge clk) begin
	if (blk_i.blk_v) begin
		data_q <= blk_i.data;            // pass through
		keep_q <= term_ok - KEEP_W'(1);  // TERM_n gives the low n bits
	end
end

assign blk_v_o   = blk_v_q;
assign ctrl_v_o  = flags_q.ctrl_v;
assign idle_v_o  = flags_q.idle_v;
assign start_v_o = flags_q.start_v;
assign term_v_o  = flags_q.term_v;
assign err_v_o   = flags_q.err_v;
assign ord_v_o   = flags_q.ord_v;
assign data_o    = data_q;
assign keep_o    = keep_q;

// a decoded block carries at most one block kind
a_one_kind: assert property (
	@(posedge clk) disable iff (rst_i)
	blk_i.blk_v |=> $onehot0({idle_v_o, |start_v_o, term_v_o, ord_v_o})
);

endmodule

`default_nettype wire

// ==== hdl/pcs_rx_top.sv ====
// pcs rx top, descrambler into block fifo into lite decoder
`include "pcs_rx_params.svh"
`default_nettype none

module pcs_rx_top (
	input wire logic                    clk,
	input wire logic                    rst_i,
	// aligned 66-bit blocks
	input wire logic                    blk_v_i,
	input wire logic [`PCS_HEAD_W-1:0]  head_i,
	input wire logic [`PCS_DATA_W-1:0]  data_i,
	input wire logic                    hold_i, // back-pressure level
	output logic                        ovf_o,  // fifo dropped a block
	// lite decode output
	output logic                        blk_v_o,
	output logic                        ctrl_v_o,
	output logic                        idle_v_o,
	output logic [`PCS_LANE0_CNT_N-1:0] start_v_o,
	output logic                        term_v_o,
	output logic                        err_v_o,
	output logic                        ord_v_o,
	output logic [`PCS_DATA_W-1:0]      data_o,
	output logic [`PCS_KEEP_W-1:0]      keep_o
);

pcs_rx_blk_if in_if ();  // top ports onto the block bus
pcs_rx_blk_if scr_if (); // descrambler to fifo
pcs_rx_blk_if buf_if (); // fifo to decoder

assign in_if.blk_v = blk_v_i;
assign in_if.head  = head_i;
assign in_if.data  = data_i;

descrambler_rx descrambler_rx_inst (
	.clk   (clk),
	.rst_i (rst_i),
	.blk_i (in_if.receiver),
	.blk_o (scr_if.sender)
);

block_fifo block_fifo_inst (
	.clk    (clk),
	.rst_i  (rst_i),
	.hold_i (hold_i),
	.ovf_o  (ovf_o),
	.wr_i   (scr_if.receiver),
	.rd_o   (buf_if.sender)
);

dec_lite_rx dec_lite_rx_inst (
	.clk       (clk),
	.rst_i     (rst_i),
	.blk_i     (buf_if.receiver),
	.blk_v_o   (blk_v_o),
	.ctrl_v_o  (ctrl_v_o),
	.idle_v_o  (idle_v_o),
	.start_v_o (start_v_o),
	.term_v_o  (term_v_o),
	.err_v_o   (err_v_o),
	.ord_v_o   (ord_v_o),
	.data_o    (data_o),
	.keep_o    (keep_o)
);

endmodule

`default_nettype wire

// ==== bench/pcs_rx_tb_tasks.svh ====
// stop, compare, drive, wait and directed test tasks of the pcs rx testbench
`ifndef PCS_RX_TB_TASKS_SVH
`define PCS_RX_TB_TASKS_SVH

task automatic stop_run(input string why);
	$display("%s", why);
	$display("TB FAILED");
	$fatal(1, "stopped at first error");
endtask

task automatic compare_flags(input dec_flags_t exp, input dec_flags_t act);
	if (act !== exp)
		stop_run($sformatf("Error: %s flags expected %h actual %h", test_name, exp, act));
endtask

task automatic compare_data(input logic [`PCS_DATA_W-1:0] exp,
		input logic [`PCS_DATA_W-1:0] act);
	if (act !== exp)
		stop_run($sformatf("Error: %s data expected %h actual %h", test_name, exp, act));
endtask

task automatic compare_keep(input logic [`PCS_KEEP_W-1:0] exp,
		input logic [`PCS_KEEP_W-1:0] act);
	if (act !== exp)
		stop_run($sformatf("Error: %s keep expected %h actual %h", test_name, exp, act));
endtask

// oldest block in flight against the dut output
task automatic check_block();
	exp_blk_t e;
	if (exp_q.size() == 0) begin
		stop_run($sformatf("%s: blk_v_o high with no block expected", test_name));
	end else begin
		e = exp_q.pop_front();
		compare_flags(e.flags, out_flags);
		compare_data(e.data, data_o);
		if (e.keep_chk)
			compare_keep(e.keep, keep_o);
	end
endtask

function automatic logic [`PCS_DATA_W-1:0] rand_payload();
	return {$random(seed), $random(seed)};
endfunction

// one block per cycle, back to back until end_burst
task automatic send_block(input logic [`PCS_HEAD_W-1:0] head,
		input logic [`PCS_DATA_W-1:0] plain);
	logic [`PCS_DATA_W-1:0] scr;
	scramble_payload(plain, scr);
	exp_q.push_back(expect_block(head, plain));
	@(posedge clk);
	#1;
	blk_v_i = 1'b1;
	head_i  = head;
	data_i  = scr;
endtask

task automatic end_burst();
	@(posedge clk);
	#1 blk_v_i = 1'b0;
endtask

// all sent blocks checked out, or give up
task automatic wait_drain();
	int cyc;
	cyc = 0;
	while (exp_q.size() != 0) begin
		@(posedge clk);
		cyc++;
		if (cyc > TMO_N)
			stop_run($sformatf("%s: timeout waiting for blk_v_o", test_name));
	end
endtask

task automatic test_reset_state();
	test_name = "reset_state";
	repeat (10) begin
		@(negedge clk);
		compare_flags('0, out_flags);
		if (blk_v_o || ovf_o)
			stop_run("blk_v_o or ovf_o high after reset with no input");
	end
endtask

task automatic test_data_blocks();
	test_name = "data_blocks";
	repeat (20) send_block(SYNC_DATA, rand_payload());
	end_burst();
	wait_drain();
endtask

// every known block type once, random bytes behind the type
task automatic test_ctrl_blocks();
	block_type_e            bt;
	logic [`PCS_DATA_W-1:0] pl;
	test_name = "ctrl_blocks";
	bt = bt.first();
	repeat (bt.num()) begin
		pl      = rand_payload();
		pl[7:0] = bt;
		send_block(SYNC_CTRL, pl);
		bt = bt.next();
	end
	end_burst();
	wait_drain();
endtask

task automatic test_malformed();
	logic [`PCS_DATA_W-1:0] pl;
	test_name = "malformed";
	send_block(2'b00, rand_payload());
	send_block(2'b11, rand_payload());
	pl      = rand_payload();
	pl[7:0] = 8'h00; // unknown type
	send_block(SYNC_CTRL, pl);
	end_burst();
	wait_drain();
endtask

task automatic test_back_pressure();
	exp_blk_t drop;
	test_name = "back_pressure";
	ovf_cnt   = 0;
	@(posedge clk);
	#1 hold_i = 1'b1;
	repeat (DEPTH + 3) send_block(SYNC_DATA, rand_payload());
	end_burst();
	repeat (3) @(posedge clk); // last block through the descrambler, its ovf seen
	if (ovf_cnt < 1 || ovf_cnt > 3)
		stop_run($sformatf("%s: %0d ovf_o pulses, 1 to 3 expected", test_name, ovf_cnt));
	repeat (ovf_cnt) drop = exp_q.pop_back(); // dropped blocks are the newest
	#1 hold_i = 1'b0;
	wait_drain();
endtask

`endif

// ==== bench/pcs_rx_tb.sv ====
// pcs rx testbench top: clock, reset, dut, reference scrambler, expected model, monitor
`include "pcs_rx_params.svh"
`default_nettype none

module pcs_rx_tb
	import pcs_rx_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int LANE_N = `PCS_LANE0_CNT_N;
localparam int DEPTH  = `PCS_FIFO_DEPTH;
localparam int TMO_N  = 100; // cycles before a wait gives up

typedef struct packed {
	dec_flags_t             flags;
	logic [`PCS_DATA_W-1:0] data;     // plain payload
	logic [`PCS_KEEP_W-1:0] keep;
	logic                   keep_chk; // keep defined on term blocks only
} exp_blk_t;

logic                   clk;
logic                   rst_i;
logic                   blk_v_i;
logic [`PCS_HEAD_W-1:0] head_i;
logic [`PCS_DATA_W-1:0] data_i;
logic                   hold_i;
logic                   ovf_o;
logic                   blk_v_o;
logic                   ctrl_v_o;
logic                   idle_v_o;
logic [LANE_N-1:0]      start_v_o;
logic                   term_v_o;
logic                   err_v_o;
logic                   ord_v_o;
logic [`PCS_DATA_W-1:0] data_o;
logic [`PCS_KEEP_W-1:0] keep_o;

dec_flags_t out_flags;  // dut flags gathered into one value
exp_blk_t   exp_q [$];  // blocks in flight, oldest first
logic [57:0] scr_state; // reference scrambler, bit 0 newest
integer     seed;
string      test_name;
int         ovf_cnt;    // ovf_o pulses seen

pcs_rx_top pcs_rx_top_inst (
	.clk       (clk),
	.rst_i     (rst_i),
	.blk_v_i   (blk_v_i),
	.head_i    (head_i),
	.data_i    (data_i),
	.hold_i    (hold_i),
	.ovf_o     (ovf_o),
	.blk_v_o   (blk_v_o),
	.ctrl_v_o  (ctrl_v_o),
	.idle_v_o  (idle_v_o),
	.start_v_o (start_v_o),
	.term_v_o  (term_v_o),
	.err_v_o   (err_v_o),
	.ord_v_o   (ord_v_o),
	.data_o    (data_o),
	.keep_o    (keep_o)
);

always_comb begin
	out_flags.ctrl_v  = ctrl_v_o;
	out_flags.idle_v  = idle_v_o;
	out_flags.start_v = start_v_o;
	out_flags.term_v  = term_v_o;
	out_flags.err_v   = err_v_o;
	out_flags.ord_v   = ord_v_o;
end

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk; // 4 ns period
end

// serial scrambler, s[n] = d[n] ^ s[n-39] ^ s[n-58], payload bit 0 first
task automatic scramble_payload(input logic [`PCS_DATA_W-1:0] plain,
		output logic [`PCS_DATA_W-1:0] scr);
	logic s;
	for (int i = 0; i < `PCS_DATA_W; i++) begin
		s = plain[i] ^ scr_state[38] ^ scr_state[57];
		scr[i] = s;
		scr_state = {scr_state[56:0], s}; // shifts on every block, any header
	end
endtask

// expected decoder result for one plain block
function automatic exp_blk_t expect_block(input logic [`PCS_HEAD_W-1:0] head,
		input logic [`PCS_DATA_W-1:0] plain);
	exp_blk_t e;
	int       term_n; // data bytes before the terminate, -1 if none
	logic     bad;
	e      = '0;
	e.data = plain;
	term_n = -1;
	bad    = 1'b0;
	if (head == SYNC_CTRL) begin
		e.flags.ctrl_v = 1'b1;
		case (plain[7:0])
			BT_CTRL:    e.flags.idle_v = 1'b1;
			BT_OS_0:    e.flags.ord_v = 1'b1;
			BT_START_0: e.flags.start_v[0] = 1'b1;
			BT_START_4: begin
				if (LANE_N > 1)
					e.flags.start_v[LANE_N-1] = 1'b1;
				else
					bad = 1'b1; // no lane 4 start in 40G
			end
			BT_TERM_0:  term_n = 0;
			BT_TERM_1:  term_n = 1;
			BT_TERM_2:  term_n = 2;
			BT_TERM_3:  term_n = 3;
			BT_TERM_4:  term_n = 4;
			BT_TERM_5:  term_n = 5;
			BT_TERM_6:  term_n = 6;
			BT_TERM_7:  term_n = 7;
			default:    bad = 1'b1;
		endcase
	end else if (head != SYNC_DATA) begin
		bad = 1'b1; // 00 and 11 are not sync headers
	end
	if (term_n >= 0) begin
		e.flags.term_v = 1'b1;
		e.keep_chk     = 1'b1;
		for (int i = 0; i < term_n; i++)
			e.keep[i] = 1'b1;
	end
	if (bad) begin
		e.flags        = '0; // error hides every block kind
		e.flags.ctrl_v = 1'b1;
		e.flags.err_v  = 1'b1;
	end
	return e;
endfunction

// outputs are registered, mid cycle is a stable point
always @(negedge clk) begin
	if (!rst_i) begin
		if (ovf_o)
			ovf_cnt++;
		if (blk_v_o)
			check_block();
	end
end

initial begin
	seed      = 32'ha313;
	scr_state = '0; // matches descrambler history after reset
	ovf_cnt   = 0;
	test_name = "reset";
	rst_i     = 1'b1;
	blk_v_i   = 1'b0;
	head_i    = '0;
	data_i    = '0;
	hold_i    = 1'b0;
	repeat (2) @(posedge clk);
	#1 rst_i = 1'b0;
	test_reset_state();
	test_data_blocks();
	test_ctrl_blocks();
	test_malformed();
	test_back_pressure();
	$display("TB PASSED");
	$finish;
end

`include "pcs_rx_tb_tasks.svh"

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
+incdir+bench
hdl/pcs_rx_pkg.sv
hdl/pcs_rx_blk_if.sv
hdl/descrambler_rx.sv
hdl/block_fifo.sv
hdl/dec_lite_rx.sv
hdl/pcs_rx_top.sv
bench/pcs_rx_tb.sv

// ==== Bender.yml ====
package:
  name: pcs_rx

sources:
  # receive path rtl
  - include_dirs:
      - hdl
    files:
      - hdl/pcs_rx_pkg.sv
      - hdl/pcs_rx_blk_if.sv
      - hdl/descrambler_rx.sv
      - hdl/block_fifo.sv
      - hdl/dec_lite_rx.sv
      - hdl/pcs_rx_top.sv
  # testbench
  - target: test
    include_dirs:
      - hdl
      - bench
    files:
      - bench/pcs_rx_tb.sv
